//--- Makefile
TOP := tb_xgmii_rx

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf obj_dir

//--- build.f
xgmii_rx_pkg.sv
xgmii_lane_align.sv
xgmii_ctrl_detect.sv
eth_fcs_check.sv
xgmii_rx_framer.sv
xgmii_rx_top.sv
tb_xgmii_rx.sv

//--- eth_fcs_check.sv
`default_nettype none

module eth_fcs_check (
    input  wire logic                     clk,
    input  wire logic                     reset_crc,
    input  wire logic                     crc_clear,
    input  wire logic                     crc_update,
    input  wire xgmii_rx_pkg::det_beat_t  det,
    output      xgmii_rx_pkg::fcs_match_t fcs
);

    import xgmii_rx_pkg::*;

    logic [31:0] crc_q;
    logic        prev_match_q;

    // crc after the first k bytes of the current word
    logic [31:0] partial [1:8];

    always_comb begin : crc_chain
        logic [31:0] c;
        c = crc_q;
        for (int k = 1; k <= 8; k++) begin
            c = crc32_byte(c, det.beat.data.lanes[k - 1]);
            partial[k] = c;
        end
    end

    // residue compares for every terminate position
    always_comb begin
        // terminate in lane 0 means the crc state alone must match
        fcs.match[0] = (crc_q == crc_residue);
        for (int k = 1; k < 8; k++) begin
            fcs.match[k] = (partial[k] == crc_residue);
        end
        fcs.prev_match = prev_match_q;
    end

    always_ff @(posedge clk) begin
        if (reset_crc || crc_clear) begin
            crc_q        <= crc_init;
            prev_match_q <= 1'b0;
        end else if (crc_update) begin
            crc_q        <= partial[8];
            // full word compare registered, keeps lane 0 off the chain
            prev_match_q <= (partial[8] == crc_residue);
        end
    end

    // framer only folds in words that belong wholly to the frame
    a_update_whole: assert property (
        @(posedge clk) disable iff (reset_crc)
        crc_update |-> (!crc_clear && (det.term_mask == 8'd0) && !det.is_start)
    );

endmodule

`default_nettype wire

//--- tb_xgmii_rx.sv
`default_nettype none

module tb_xgmii_rx;

    timeunit 1ns;
    timeprecision 100ps;

    import xgmii_rx_pkg::*;

    logic        clk;
    logic        reset_crc;
    xgmii_beat_t rx;
    axis_beat_t  m_axis;
    rx_status_t  status;

    // input byte stream, {ctrl, data} per lane
    logic [8:0]  in_q [$];
    axis_beat_t  exp_beats [$];
    rx_status_t  exp_status [$];

    logic [7:0]  payload [0:127];
    logic [7:0]  body [0:131];

    int          beat_errors;
    int          status_errors;
    int          other_errors;
    int          cycle_count;
    int          limit;
    int          nwords;
    logic        in_frame;
    axis_beat_t  exp_beat;
    rx_status_t  exp_stat;

    xgmii_rx_top dut_i (
        .clk       (clk),
        .reset_crc (reset_crc),
        .rx        (rx),
        .m_axis    (m_axis),
        .status    (status)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // bitwise ethernet crc over the payload, inverted at the end
    function automatic logic [31:0] ref_fcs(input int len);
        logic [31:0] crc;
        logic        fb;
        crc = 32'hffff_ffff;
        for (int n = 0; n < len; n++) begin
            for (int b = 0; b < 8; b++) begin
                fb  = crc[0] ^ payload[n][b];
                crc = crc >> 1;
                if (fb) begin
                    crc = crc ^ 32'hedb8_8320;
                end
            end
        end
        return ~crc;
    endfunction

    function automatic logic [63:0] keep_bytes(input logic [7:0] keep);
        logic [63:0] m;
        for (int i = 0; i < 8; i++) begin
            m[8*i +: 8] = {8{keep[i]}};
        end
        return m;
    endfunction

    function automatic xgmii_beat_t idle_word();
        xgmii_beat_t w;
        for (int i = 0; i < 8; i++) begin
            w.data.lanes[i] = xgmii_idle;
        end
        w.ctrl = 8'hff;
        return w;
    endfunction

    // err_pos < 0 means no error character in the frame
    task automatic add_frame(input int len, input bit lane4, input bit corrupt, input int err_pos);
        logic [31:0] fcs;
        int          flip;
        int          body_len;
        int          start;
        int          nbeats;
        axis_beat_t  e;
        rx_status_t  s;
        for (int n = 0; n < len; n++) begin
            payload[n] = 8'($urandom);
            body[n]    = payload[n];
        end
        fcs = ref_fcs(len);
        if (corrupt) begin
            flip = $urandom % 32;
            fcs  = fcs ^ (32'd1 << flip);
        end
        for (int n = 0; n < 4; n++) begin
            body[len + n] = fcs[8*n +: 8];
        end
        body_len = len + 4;

        // one idle word at least, then move to the start lane
        repeat (8) in_q.push_back({1'b1, xgmii_idle});
        while (in_q.size() % 8 != (lane4 ? 4 : 0)) begin
            in_q.push_back({1'b1, xgmii_idle});
        end
        start = in_q.size();
        in_q.push_back({1'b1, xgmii_start});
        repeat (6) in_q.push_back({1'b0, 8'h55});
        in_q.push_back({1'b0, 8'hd5});
        for (int n = 0; n < body_len; n++) begin
            if (n == err_pos) begin
                in_q.push_back({1'b1, xgmii_error});
            end else begin
                in_q.push_back({1'b0, body[n]});
            end
        end
        in_q.push_back({1'b1, xgmii_term});
        while ((in_q.size() - start) % 8 != 0) begin
            in_q.push_back({1'b1, xgmii_idle});
        end

        if (err_pos >= 0 && err_pos < 8) begin
            // frame never gets past its first word
            e           = '0;
            e.keep      = 8'h01;
            e.valid     = 1'b1;
            e.last      = 1'b1;
            e.user      = 1'b1;
            s           = '0;
            s.bad_frame = 1'b1;
            exp_beats.push_back(e);
            exp_status.push_back(s);
        end else begin
            if (err_pos >= 0) begin
                nbeats = err_pos / 8 + 1;
            end else begin
                nbeats = (body_len + 7) / 8;
            end
            for (int w = 0; w < nbeats; w++) begin
                e       = '0;
                s       = '0;
                e.valid = 1'b1;
                for (int i = 0; i < 8; i++) begin
                    if (8*w + i < body_len) begin
                        e.data[8*i +: 8] = body[8*w + i];
                        e.keep[i]        = 1'b1;
                    end
                end
                if (w == nbeats - 1) begin
                    e.last = 1'b1;
                    if (err_pos >= 0) begin
                        e.keep[err_pos % 8] = 1'b0;
                        e.user              = 1'b1;
                        s.bad_frame         = 1'b1;
                    end else begin
                        e.user      = corrupt;
                        s.bad_frame = corrupt;
                        s.bad_fcs   = corrupt;
                    end
                end
                exp_beats.push_back(e);
                exp_status.push_back(s);
            end
        end
    endtask

    task automatic drive_word(input int w);
        xgmii_beat_t word;
        for (int i = 0; i < 8; i++) begin
            word.data.lanes[i] = in_q[8*w + i][7:0];
            word.ctrl[i]       = in_q[8*w + i][8];
        end
        rx = word;
    endtask

    task automatic check_beat(input axis_beat_t got, input axis_beat_t exp);
        logic [63:0] m;
        m = keep_bytes(exp.keep);
        if (((got.data & m) !== (exp.data & m)) || (got.keep !== exp.keep)
                || (got.last !== exp.last) || (got.user !== exp.user)) begin
            beat_errors++;
            $display("[FAIL] %t: beat data %h keep %h last %b user %b", $time,
                     got.data, got.keep, got.last, got.user);
            $display("       expected data %h keep %h last %b user %b",
                     exp.data, exp.keep, exp.last, exp.user);
        end
    endtask

    task automatic check_status(input rx_status_t got, input rx_status_t exp);
        if (got !== exp) begin
            status_errors++;
            $display("[FAIL] %t: status bad_frame %b bad_fcs %b, expected %b %b", $time,
                     got.bad_frame, got.bad_fcs, exp.bad_frame, exp.bad_fcs);
        end
    endtask

    // compare process, outputs settle one edge earlier
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > 1) begin
            if (m_axis.valid === 1'b1) begin
                if (exp_beats.size() == 0) begin
                    other_errors++;
                    $display("unexpected beat at %t, no beat was expected", $time);
                    check_status(status, '0);
                end else begin
                    exp_beat = exp_beats.pop_front();
                    exp_stat = exp_status.pop_front();
                    check_beat(m_axis, exp_beat);
                    check_status(status, exp_stat);
                end
            end else begin
                if (m_axis.valid !== 1'b0) begin
                    other_errors++;
                    $display("valid is unknown at %t", $time);
                end
                if (in_frame) begin
                    other_errors++;
                    $display("frame interrupted at %t, valid dropped before last", $time);
                end
                check_status(status, '0);
            end
            in_frame = (m_axis.valid === 1'b1) && (m_axis.last !== 1'b1);
        end
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'h8861));
        beat_errors   = 0;
        status_errors = 0;
        other_errors  = 0;
        cycle_count   = 0;
        in_frame      = 1'b0;
        reset_crc     = 1'b1;
        rx            = idle_word();

        // good frames, terminate lands in every lane
        for (int n = 0; n < 8; n++) begin
            add_frame(40 + n, 1'b0, 1'b0, -1);
        end
        for (int n = 0; n < 8; n++) begin
            add_frame(40 + n, 1'b1, 1'b0, -1);
        end
        // one flipped fcs bit
        for (int n = 0; n < 4; n++) begin
            add_frame(41 + 3*n, n[0], 1'b1, -1);
        end
        // error character deeper in the payload
        for (int n = 0; n < 4; n++) begin
            add_frame(40, n[0], 1'b0, 8 + int'($urandom % 16));
        end
        // control character right behind the start word
        add_frame(20, 1'b0, 1'b0, int'($urandom % 8));
        add_frame(20, 1'b1, 1'b0, int'($urandom % 8));
        // random back to back traffic
        for (int n = 0; n < 12; n++) begin
            add_frame(1 + int'($urandom % 80), ($urandom % 2) == 1, ($urandom % 4) == 0, -1);
        end
        repeat (128) in_q.push_back({1'b1, xgmii_idle});
        nwords = in_q.size() / 8;
        limit  = 16 + 4 + nwords + 200;

        repeat (16) @(negedge clk);
        reset_crc = 1'b0;
        repeat (4) @(negedge clk);

        for (int w = 0; w < nwords; w++) begin
            @(negedge clk);
            drive_word(w);
        end
        @(negedge clk);
        rx = idle_word();

        while (exp_beats.size() != 0 && cycle_count < limit) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);

        if (cycle_count >= limit) begin
            other_errors++;
            $display("timeout: cycle limit of %0d reached", limit);
        end
        if (exp_beats.size() != 0) begin
            other_errors++;
            $display("%0d expected beats were never received", exp_beats.size());
        end

        $display("errors: beat %0d, status %0d, other %0d",
                 beat_errors, status_errors, other_errors);
        if (beat_errors + status_errors + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- xgmii_ctrl_detect.sv
`default_nettype none

module xgmii_ctrl_detect (
    input  wire logic                      clk,
    input  wire logic                      reset_crc,
    input  wire xgmii_rx_pkg::xgmii_beat_t aligned,
    output      xgmii_rx_pkg::det_beat_t   det
);

    import xgmii_rx_pkg::*;

    logic [7:0] term_lanes;
    logic [7:0] term_first;
    logic [7:0] keep;
    logic       is_start;
    logic       bad_ctrl;

    // per lane terminate compare
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            term_lanes[i] = aligned.ctrl[i] && (aligned.data.lanes[i] == xgmii_term);
        end
    end

    assign is_start = aligned.ctrl[0] && (aligned.data.lanes[0] == xgmii_start);

    // isolate lowest terminate
    assign term_first = term_lanes & (~term_lanes + 8'd1);

    // lanes below the terminate, all lanes when there is none
    assign keep = term_first - 8'd1;

    // anything but data in the frame part of the word is bad
    always_comb begin
        if (is_start) begin
            bad_ctrl = |aligned.ctrl[7:1];
        end else begin
            bad_ctrl = |(aligned.ctrl & keep);
        end
    end

    always_ff @(posedge clk) begin
        det.beat.data <= aligned.data;
        det.keep_mask <= keep;

        if (reset_crc) begin
            det.beat.ctrl <= 8'd0;
            det.is_start  <= 1'b0;
            det.term_mask <= 8'd0;
            det.bad_ctrl  <= 1'b0;
        end else begin
            det.beat.ctrl <= aligned.ctrl;
            det.is_start  <= is_start;
            det.term_mask <= term_first;
            det.bad_ctrl  <= bad_ctrl;
        end
    end

endmodule

`default_nettype wire

//--- xgmii_lane_align.sv
`default_nettype none

module xgmii_lane_align (
    input  wire logic                      clk,
    input  wire logic                      reset_crc,
    input  wire xgmii_rx_pkg::xgmii_beat_t rx,
    output      xgmii_rx_pkg::xgmii_beat_t aligned
);

    import xgmii_rx_pkg::*;

    logic        swapped_q;
    logic [31:0] upper_q;
    logic [3:0]  upper_ctrl_q;
    logic        start0;
    logic        start4;
    logic        use_swap;

    assign start0 = rx.ctrl[0] && (rx.data.lanes[0] == xgmii_start);
    assign start4 = rx.ctrl[4] && (rx.data.lanes[4] == xgmii_start);

    // a lane 0 start always wins and drops back to straight mode
    assign use_swap = !start0 && (start4 || swapped_q);

    always_ff @(posedge clk) begin
        upper_q <= rx.data.halves[1];

        // upper half of last word becomes the lower half of this one
        if (use_swap) begin
            aligned.data.halves <= {rx.data.halves[0], upper_q};
        end else begin
            aligned.data <= rx.data;
        end

        if (reset_crc) begin
            swapped_q    <= 1'b0;
            upper_ctrl_q <= 4'd0;
            aligned.ctrl <= 8'd0;
        end else begin
            upper_ctrl_q <= rx.ctrl[7:4];

            if (start0) begin
                swapped_q <= 1'b0;
            end else if (start4) begin
                swapped_q <= 1'b1;
            end

            if (use_swap) begin
                aligned.ctrl <= {rx.ctrl[3:0], upper_ctrl_q};
            end else begin
                aligned.ctrl <= rx.ctrl;
            end
        end
    end

    // only one start position per column pair
    a_single_start: assert property (
        @(posedge clk) disable iff (reset_crc)
        !(start0 && start4)
    );

    // lane 4 start reaches lane 0 once the next half word is in
    a_lane4_moved: assert property (
        @(posedge clk) disable iff (reset_crc)
        start4 |-> ##2 (aligned.ctrl[0] && (aligned.data.lanes[0] == xgmii_start))
    );

endmodule

`default_nettype wire

//--- xgmii_rx_framer.sv
`default_nettype none

module xgmii_rx_framer (
    input  wire logic                     clk,
    input  wire logic                     reset_crc,
    input  wire xgmii_rx_pkg::det_beat_t  det,
    input  wire xgmii_rx_pkg::fcs_match_t fcs,
    output      logic                     crc_clear,
    output      logic                     crc_update,
    output      xgmii_rx_pkg::axis_beat_t m_axis,
    output      xgmii_rx_pkg::rx_status_t status
);

    import xgmii_rx_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_payload,
        st_flush
    } state_t;

    state_t     state_q;
    state_t     state_d;
    axis_beat_t hold_q;
    axis_beat_t hold_d;
    rx_status_t hold_status_q;
    rx_status_t hold_status_d;
    axis_beat_t out_d;
    rx_status_t status_d;
    axis_beat_t err_beat;
    axis_beat_t word_beat;
    logic       fcs_ok;

    always_comb begin
        // lone bad beat for a frame that never got going
        err_beat       = '0;
        err_beat.keep  = 8'h01;
        err_beat.valid = 1'b1;
        err_beat.last  = 1'b1;
        err_beat.user  = 1'b1;

        word_beat       = '0;
        word_beat.data  = det.beat.data;
        word_beat.keep  = det.keep_mask;
        word_beat.valid = 1'b1;
    end

    assign fcs_ok = det.term_mask[0] ? fcs.prev_match
                                     : |(det.term_mask[7:1] & fcs.match[7:1]);

    always_comb begin
        state_d       = state_q;
        hold_d        = '0;
        hold_status_d = '0;
        out_d         = '0;
        status_d      = '0;
        crc_clear     = 1'b0;
        crc_update    = 1'b0;

        case (state_q)
            st_idle, st_flush: begin
                // closed beat of the last frame leaves now
                if (state_q == st_flush) begin
                    out_d    = hold_q;
                    status_d = hold_status_q;
                end
                crc_clear = 1'b1;
                state_d   = st_idle;
                if (det.is_start) begin
                    if (det.bad_ctrl) begin
                        hold_d                  = err_beat;
                        hold_status_d.bad_frame = 1'b1;
                        state_d                 = st_flush;
                    end else begin
                        state_d = st_payload;
                    end
                end
            end

            st_payload: begin
                // previous word goes out unless it is the first one
                out_d = hold_q;
                if (det.bad_ctrl) begin
                    crc_clear               = 1'b1;
                    hold_status_d.bad_frame = 1'b1;
                    state_d                 = st_flush;
                    if (!hold_q.valid) begin
                        hold_d = err_beat;
                    end else begin
                        hold_d      = word_beat;
                        hold_d.keep = det.keep_mask & ~det.beat.ctrl;
                        hold_d.last = 1'b1;
                        hold_d.user = 1'b1;
                    end
                end else if (det.term_mask[0]) begin
                    crc_clear = 1'b1;
                    if (!hold_q.valid) begin
                        // empty frame
                        hold_d                  = err_beat;
                        hold_status_d.bad_frame = 1'b1;
                        state_d                 = st_flush;
                    end else begin
                        // held beat is the end of the frame
                        out_d.last         = 1'b1;
                        out_d.user         = !fcs_ok;
                        status_d.bad_frame = !fcs_ok;
                        status_d.bad_fcs   = !fcs_ok;
                        state_d            = st_idle;
                    end
                end else if (|det.term_mask) begin
                    crc_clear               = 1'b1;
                    hold_d                  = word_beat;
                    hold_d.last             = 1'b1;
                    hold_d.user             = !fcs_ok;
                    hold_status_d.bad_frame = !fcs_ok;
                    hold_status_d.bad_fcs   = !fcs_ok;
                    state_d                 = st_flush;
                end else begin
                    crc_update = 1'b1;
                    hold_d     = word_beat;
                end
            end

            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        hold_q.data <= hold_d.data;
        hold_q.keep <= hold_d.keep;
        m_axis.data <= out_d.data;
        m_axis.keep <= out_d.keep;

        if (reset_crc) begin
            state_q       <= st_idle;
            hold_q.valid  <= 1'b0;
            hold_q.last   <= 1'b0;
            hold_q.user   <= 1'b0;
            hold_status_q <= '0;
            m_axis.valid  <= 1'b0;
            m_axis.last   <= 1'b0;
            m_axis.user   <= 1'b0;
            status        <= '0;
        end else begin
            state_q       <= state_d;
            hold_q.valid  <= hold_d.valid;
            hold_q.last   <= hold_d.last;
            hold_q.user   <= hold_d.user;
            hold_status_q <= hold_status_d;
            m_axis.valid  <= out_d.valid;
            m_axis.last   <= out_d.last;
            m_axis.user   <= out_d.user;
            status        <= status_d;
        end
    end

    a_last_valid: assert property (
        @(posedge clk) disable iff (reset_crc)
        m_axis.last |-> m_axis.valid
    );

    a_user_last: assert property (
        @(posedge clk) disable iff (reset_crc)
        m_axis.user |-> m_axis.last
    );

    a_fcs_frame: assert property (
        @(posedge clk) disable iff (reset_crc)
        status.bad_fcs |-> status.bad_frame
    );

endmodule

`default_nettype wire

//--- xgmii_rx_pkg.sv
`default_nettype none

package xgmii_rx_pkg;

    // XGMII control characters
    localparam logic [7:0] xgmii_idle  = 8'h07;
    localparam logic [7:0] xgmii_start = 8'hfb;
    localparam logic [7:0] xgmii_term  = 8'hfd;
    localparam logic [7:0] xgmii_error = 8'hfe;

    // Ethernet CRC-32, reflected form
    localparam logic [31:0] crc_init     = 32'hffff_ffff;
    localparam logic [31:0] crc_poly_rev = 32'hedb8_8320;
    // state after data plus a correct FCS, no final inversion
    localparam logic [31:0] crc_residue  = 32'hdebb_20e3;

    // one XGMII data word, seen as byte lanes or as two half words
    typedef union packed {
        logic [7:0][7:0]  lanes;
        logic [1:0][31:0] halves;
    } xgmii_data_u;

    typedef struct packed {
        xgmii_data_u data;
        logic [7:0]  ctrl;
    } xgmii_beat_t;

    // word plus the per-lane decode of the detect stage
    typedef struct packed {
        xgmii_beat_t beat;
        logic        is_start;
        logic [7:0]  term_mask;
        logic        bad_ctrl;
        logic [7:0]  keep_mask;
    } det_beat_t;

    // match[k]: crc over the bytes before lane k hits the residue
    typedef struct packed {
        logic [7:0] match;
        logic       prev_match;
    } fcs_match_t;

    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        valid;
        logic        last;
        logic        user;
    } axis_beat_t;

    typedef struct packed {
        logic bad_frame;
        logic bad_fcs;
    } rx_status_t;

    // one byte through the reflected galois crc, lsb first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ crc_poly_rev;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

`default_nettype wire

//--- xgmii_rx_top.sv
`default_nettype none

module xgmii_rx_top (
    input  wire logic                      clk,
    input  wire logic                      reset_crc,
    input  wire xgmii_rx_pkg::xgmii_beat_t rx,
    output      xgmii_rx_pkg::axis_beat_t  m_axis,
    output      xgmii_rx_pkg::rx_status_t  status
);

    import xgmii_rx_pkg::*;

    xgmii_beat_t aligned;
    det_beat_t   det;
    fcs_match_t  fcs;
    logic        crc_clear;
    logic        crc_update;

    xgmii_lane_align u_align (
        .clk       (clk),
        .reset_crc (reset_crc),
        .rx        (rx),
        .aligned   (aligned)
    );

    xgmii_ctrl_detect u_detect (
        .clk       (clk),
        .reset_crc (reset_crc),
        .aligned   (aligned),
        .det       (det)
    );

    // crc runs alongside the framer on the same detected word
    eth_fcs_check u_fcs (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .det        (det),
        .fcs        (fcs)
    );

    xgmii_rx_framer u_framer (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .det        (det),
        .fcs        (fcs),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .m_axis     (m_axis),
        .status     (status)
    );

endmodule

`default_nettype wire
